//--- project.f
rtl/cru_bus_pkg.sv
rtl/psi_pkg.sv
rtl/cru_host_port.sv
rtl/psi_timer.sv
rtl/psi_io_core.sv
rtl/psi_int_encoder.sv
rtl/psi_top.sv
sim/psi_tb.sv

//--- Makefile
run: obj_dir/Vpsi_tb
	./obj_dir/Vpsi_tb | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

obj_dir/Vpsi_tb: project.f $(wildcard rtl/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module psi_tb -f project.f -o Vpsi_tb

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- sim/psi_tb.sv
`timescale 1ns/1ps

module psi_tb;
   import cru_bus_pkg::*;
   import psi_pkg::*;

   localparam int PREDIV_BITS = 3;
   localparam int RESET_CYCLES = 16;
   localparam int TXN_MAX_CYCLES = 8; // an unstalled handshake takes five clocks.
   localparam int TIMER_TXNS = 40;
   localparam int CLOCK_VALUE = 5;
   localparam int ENCODER_DELAY = 2;
   localparam int TIMER_LO = (CLOCK_VALUE << PREDIV_BITS) + ENCODER_DELAY;
   localparam int TIMER_HI = ((CLOCK_VALUE + 1) << PREDIV_BITS) + ENCODER_DELAY;
   localparam int PIN_SPACE = 16; // s[0] set selects the pins.
   localparam logic [1:6] INT_IDLE = 6'b111111;
   localparam logic [0:15] PIN_IDLE = 16'hffff;

   typedef struct packed {
      logic [3:0]  test_id;
      cru_op_t     op;
      logic [0:4]  addr;
      logic        wdata;
      logic [1:6]  int_in;
      logic [0:15] p_in;
      logic        exp_rd;
      logic [0:15] exp_p_out;
      logic [0:15] exp_p_dir;
      logic        exp_intreq;
      logic [0:3]  exp_ic;
   } stim_row_t;

   logic         clk;
   logic         reset;
   logic         clk_en;
   logic         req;
   cru_request_t request;
   logic         ack;
   logic         rd_data;
   logic [1:6]   int_in;
   logic [0:15]  p_in;
   logic [0:15]  p_out;
   logic [0:15]  p_dir;
   logic         intreq;
   logic [0:3]   ic;

   stim_row_t   stim_table[$];
   logic [31:0] lfsr_state;
   int          cycle_count;
   int          cycle_limit;
   int          error_count;
   int          test_errors;
   int          tests_run;
   int          tests_failed;
   logic        timer_armed;
   logic        timer_seen;
   int          timer_start;
   int          timer_hit;

   // reference copy of the register map state.
   logic [0:15] m_p_out;
   logic [0:15] m_p_dir;
   logic [1:15] m_mask;
   logic        m_ctrl;

   psi_top #(
      .PREDIV_BITS(PREDIV_BITS)
   ) psi_top_inst (
      .clk(clk),
      .reset(reset),
      .clk_en(clk_en),
      .req(req),
      .request(request),
      .ack(ack),
      .rd_data(rd_data),
      .int_in(int_in),
      .p_in(p_in),
      .p_out(p_out),
      .p_dir(p_dir),
      .intreq(intreq),
      .ic(ic)
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   always @(posedge clk) begin
      #1;
      if (timer_armed && !timer_seen && ic == 4'(TIMER_LEVEL)) begin
         timer_seen = 1'b1; // first edge at which the timer level shows on ic.
         timer_hit = cycle_count;
      end
   end

   // ************************************************************
   // random bits and reference model
   // ************************************************************

   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      logic [31:0] next;
      next = state >> 1;
      if (state[0]) begin
         next = next ^ 32'h8020_0003;
      end
      return next;
   endfunction

   task automatic take_bit(output logic b);
      b = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
   endtask

   task automatic take_bits(input int n, output logic [15:0] v);
      logic b;
      v = '0;
      for (int i = 0; i < n; i++) begin
         take_bit(b);
         v = {v[14:0], b};
      end
   endtask

   function automatic logic pin_value(input int i, input logic [0:15] pins);
      return m_p_dir[i] ? m_p_out[i] : pins[i];
   endfunction

   function automatic logic level_input(input int l, input logic [1:6] iin,
                                        input logic [0:15] pins);
      if (l <= 6) begin
         return iin[l];
      end
      return pin_value(22 - l, pins); // levels 7 to 15 count down the pins.
   endfunction

   function automatic logic any_active(input logic [1:6] iin, input logic [0:15] pins);
      for (int l = 1; l <= 15; l++) begin
         if (m_mask[l] && !level_input(l, iin, pins)) begin
            return 1'b1;
         end
      end
      return 1'b0;
   endfunction

   function automatic logic [0:3] lowest_level(input logic [1:6] iin, input logic [0:15] pins);
      for (int l = 1; l <= 15; l++) begin
         if (m_mask[l] && !level_input(l, iin, pins)) begin
            return 4'(l);
         end
      end
      return 4'b1111;
   endfunction

   function automatic logic model_read(input logic [0:4] addr, input logic [1:6] iin,
                                       input logic [0:15] pins);
      int idx;
      idx = int'(addr[1:4]);
      if (addr[0]) begin
         return pin_value(idx, pins);
      end else if (idx == 0) begin
         return m_ctrl;
      end else if (m_ctrl) begin
         return (idx == 15) ? any_active(iin, pins) : 1'b0; // idle timer reads zero.
      end else if (idx <= 6) begin
         return iin[idx];
      end
      return pin_value(22 - idx, pins);
   endfunction

   task automatic model_write(input logic [0:4] addr, input logic d);
      int idx;
      idx = int'(addr[1:4]);
      if (addr[0]) begin
         m_p_out[idx] = d;
         m_p_dir[idx] = 1'b1;
      end else if (idx == 0) begin
         m_ctrl = d;
      end else if (m_ctrl) begin
         if (idx == 15 && d) begin
            m_p_out = '0;
            m_p_dir = '0;
            m_mask = '0;
         end
      end else begin
         m_mask[idx] = d;
      end
   endtask

   task automatic add_row(input int test_id, input cru_op_t op, input int addr,
                          input logic d, input logic [1:6] iin, input logic [0:15] pins);
      stim_row_t row;
      row.test_id = 4'(test_id);
      row.op = op;
      row.addr = 5'(addr);
      row.wdata = d;
      row.int_in = iin;
      row.p_in = pins;
      row.exp_rd = (op == CRU_READ) ? model_read(row.addr, iin, pins) : 1'b0;
      if (op == CRU_WRITE) begin
         model_write(row.addr, d);
      end
      row.exp_p_out = m_p_out;
      row.exp_p_dir = m_p_dir;
      row.exp_intreq = any_active(iin, pins);
      row.exp_ic = lowest_level(iin, pins);
      stim_table.push_back(row);
   endtask

   // ************************************************************
   // stimulus table
   // ************************************************************

   task automatic build_table();
      logic        b;
      logic [15:0] pins;
      logic [15:0] ints;
      for (int i = 0; i < 16; i++) begin
         take_bit(b);
         add_row(1, CRU_WRITE, PIN_SPACE + i, b, INT_IDLE, PIN_IDLE);
      end
      for (int i = 0; i < 16; i++) begin
         take_bits(16, pins); // driven pins ignore p_in.
         add_row(1, CRU_READ, PIN_SPACE + i, 1'b0, INT_IDLE, pins);
      end
      add_row(2, CRU_WRITE, 0, 1'b1, INT_IDLE, PIN_IDLE);
      add_row(2, CRU_WRITE, 15, 1'b1, INT_IDLE, PIN_IDLE);
      add_row(2, CRU_WRITE, 0, 1'b0, INT_IDLE, PIN_IDLE);
      take_bits(16, pins);
      take_bits(6, ints);
      for (int i = 0; i < 16; i++) begin
         add_row(2, CRU_READ, PIN_SPACE + i, 1'b0, ints[5:0], pins);
      end
      for (int a = 0; a < 16; a++) begin
         add_row(2, CRU_READ, a, 1'b0, ints[5:0], pins);
      end
      add_row(3, CRU_WRITE, 2, 1'b1, INT_IDLE, PIN_IDLE);
      add_row(3, CRU_WRITE, 5, 1'b1, INT_IDLE, PIN_IDLE);
      add_row(3, CRU_WRITE, 9, 1'b1, INT_IDLE, PIN_IDLE);
      add_row(3, CRU_READ, 1, 1'b0, 6'b101111, PIN_IDLE);
      add_row(3, CRU_READ, 1, 1'b0, 6'b111101, PIN_IDLE);
      add_row(3, CRU_READ, 1, 1'b0, INT_IDLE, 16'hfffb); // pin 13 carries level 9.
      add_row(3, CRU_READ, 1, 1'b0, 6'b111101, 16'hfffb);
      add_row(3, CRU_READ, 1, 1'b0, 6'b101101, 16'hfffb);
      add_row(3, CRU_READ, 1, 1'b0, 6'b011011, 16'hfffd);
      add_row(3, CRU_WRITE, 0, 1'b1, INT_IDLE, PIN_IDLE);
      add_row(3, CRU_READ, 15, 1'b0, 6'b111101, PIN_IDLE);
      add_row(3, CRU_READ, 15, 1'b0, INT_IDLE, PIN_IDLE);
      add_row(3, CRU_WRITE, 0, 1'b0, INT_IDLE, PIN_IDLE);
      add_row(4, CRU_WRITE, PIN_SPACE + 13, 1'b0, INT_IDLE, PIN_IDLE);
      add_row(4, CRU_WRITE, PIN_SPACE + 2, 1'b1, INT_IDLE, PIN_IDLE);
      add_row(4, CRU_WRITE, 0, 1'b1, INT_IDLE, PIN_IDLE);
      add_row(4, CRU_WRITE, 15, 1'b1, INT_IDLE, PIN_IDLE);
      add_row(4, CRU_WRITE, 0, 1'b0, INT_IDLE, PIN_IDLE);
      add_row(4, CRU_READ, 2, 1'b0, 6'b101111, PIN_IDLE);
   endtask

   function automatic string test_name(input logic [3:0] id);
      case (id)
         4'd1: return "pin writes";
         4'd2: return "pin inputs";
         4'd3: return "interrupt priority";
         default: return "soft reset";
      endcase
   endfunction

   // ************************************************************
   // driver and checks
   // ************************************************************

   task automatic run_transaction(input cru_op_t op, input logic [0:4] addr, input logic d,
                                  output logic rd);
      request.op = op;
      request.addr = addr;
      request.wdata = d;
      req = 1'b1;
      while (!ack) begin
         @(posedge clk);
         #1;
      end
      rd = rd_data;
      req = 1'b0;
      while (ack) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic note_error();
      error_count++;
      test_errors++;
   endtask

   task automatic check_value(input string name, input logic [15:0] got,
                              input logic [15:0] expected);
      assert (got === expected) else begin
         $display("[ERROR] time %0t: %s expected %h, got %h", $time, name, expected, got);
         note_error();
      end
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (test_errors == 0) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: %0d errors", tests_run, name, test_errors);
      end
      test_errors = 0;
   endtask

   task automatic read_timer_value(output logic [TIMER_BITS:1] value);
      logic rd;
      value = '0;
      for (int n = 1; n <= TIMER_BITS; n++) begin
         run_transaction(CRU_READ, 5'(n), 1'b0, rd);
         value[n] = rd;
      end
   endtask

   task automatic run_timer_tests();
      logic                rd;
      logic [TIMER_BITS:1] load;
      logic [TIMER_BITS:1] first_value;
      logic [TIMER_BITS:1] second_value;
      int                  latency;
      int_in = INT_IDLE;
      p_in = PIN_IDLE;
      load = TIMER_BITS'(CLOCK_VALUE);
      run_transaction(CRU_WRITE, 5'd0, 1'b1, rd);
      for (int n = TIMER_BITS; n >= 1; n--) begin
         if (load[n]) begin
            run_transaction(CRU_WRITE, 5'(n), 1'b1, rd);
         end
      end
      timer_start = cycle_count - 2; // the write landed at the edge that raised ack.
      timer_armed = 1'b1;
      run_transaction(CRU_WRITE, 5'd0, 1'b0, rd);
      run_transaction(CRU_WRITE, 5'(TIMER_LEVEL), 1'b1, rd);
      run_transaction(CRU_WRITE, 5'd0, 1'b1, rd);
      read_timer_value(first_value);
      read_timer_value(second_value);
      check_value("read_reg", 16'(second_value), 16'(first_value));
      assert (first_value < load) else begin
         $display("read register showed %0d, not below the loaded value %0d",
                  first_value, load);
         note_error();
      end
      finish_test("read register freeze");
      while (!timer_seen) begin
         @(posedge clk);
         #1;
      end
      latency = timer_hit - timer_start;
      assert (latency >= TIMER_LO && latency <= TIMER_HI) else begin
         $display("timer level reached ic after %0d cycles, outside %0d to %0d",
                  latency, TIMER_LO, TIMER_HI);
         note_error();
      end
      check_value("ic", 16'(ic), 16'(TIMER_LEVEL));
      check_value("intreq", 16'(intreq), 16'd1);
      run_transaction(CRU_WRITE, 5'd0, 1'b0, rd);
      run_transaction(CRU_WRITE, 5'(TIMER_LEVEL), 1'b1, rd); // clears the timer flag.
      check_value("ic", 16'(ic), 16'(NO_INT_CODE));
      check_value("intreq", 16'(intreq), 16'd0);
      finish_test("timer interrupt");
   endtask

   initial begin
      stim_row_t row;
      logic      rd;
      clk = 1'b0;
      reset = 1'b1;
      clk_en = 1'b1;
      req = 1'b0;
      request = '0;
      int_in = INT_IDLE;
      p_in = PIN_IDLE;
      lfsr_state = 32'h1ba3_5065;
      cycle_count = 0;
      cycle_limit = 0;
      error_count = 0;
      test_errors = 0;
      tests_run = 0;
      tests_failed = 0;
      timer_armed = 1'b0;
      timer_seen = 1'b0;
      timer_start = 0;
      timer_hit = 0;
      m_p_out = '0;
      m_p_dir = '0;
      m_mask = '0;
      m_ctrl = 1'b0;
      build_table();
      cycle_limit = RESET_CYCLES + (stim_table.size() + TIMER_TXNS) * TXN_MAX_CYCLES
                    + 2 * TIMER_HI;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      reset = 1'b0;
      for (int i = 0; i < stim_table.size(); i++) begin
         row = stim_table[i];
         if (i > 0 && row.test_id != stim_table[i-1].test_id) begin
            finish_test(test_name(stim_table[i-1].test_id));
         end
         int_in = row.int_in;
         p_in = row.p_in;
         run_transaction(row.op, row.addr, row.wdata, rd);
         check_value("rd_data", 16'(rd), 16'(row.exp_rd));
         check_value("p_out", 16'(p_out), 16'(row.exp_p_out));
         check_value("p_dir", 16'(p_dir), 16'(row.exp_p_dir));
         check_value("intreq", 16'(intreq), 16'(row.exp_intreq));
         check_value("ic", 16'(ic), 16'(row.exp_ic));
      end
      finish_test(test_name(stim_table[stim_table.size()-1].test_id));
      run_timer_tests();
      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
      if (error_count == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

//--- rtl/psi_top.sv
`timescale 1ns/1ps

module psi_top #(
   parameter int PREDIV_BITS = 6
) (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      clk_en,
   input  logic                      req,
   input  cru_bus_pkg::cru_request_t request,
   output logic                      ack,
   output logic                      rd_data,
   input  logic [1:6]                int_in,
   input  logic [0:15]               p_in,
   output logic [0:15]               p_out,
   output logic [0:15]               p_dir,
   output logic                      intreq,
   output logic [0:3]                ic
);
   import cru_bus_pkg::*;
   import psi_pkg::*;

   cru_cycle_t          cycle;
   logic                cruin;
   logic [1:NUM_LEVELS] int_mask;
   logic [1:NUM_LEVELS] int_level;

   cru_host_port cru_host_port_inst (
      .clk(clk),
      .reset(reset),
      .req(req),
      .request(request),
      .cruin(cruin),
      .ack(ack),
      .rd_data(rd_data),
      .cycle(cycle)
   );

   psi_io_core #(
      .PREDIV_BITS(PREDIV_BITS)
   ) psi_io_core_inst (
      .clk(clk),
      .reset(reset),
      .clk_en(clk_en),
      .cycle(cycle),
      .int_in(int_in),
      .p_in(p_in),
      .intreq(intreq),
      .cruin(cruin),
      .p_out(p_out),
      .p_dir(p_dir),
      .int_mask(int_mask),
      .int_level(int_level)
   );

   psi_int_encoder psi_int_encoder_inst (
      .clk(clk),
      .reset(reset),
      .int_level(int_level),
      .int_mask(int_mask),
      .intreq(intreq),
      .ic(ic)
   );

endmodule

//--- rtl/psi_int_encoder.sv
`timescale 1ns/1ps

module psi_int_encoder (
   input  logic                         clk,
   input  logic                         reset,
   input  logic [1:psi_pkg::NUM_LEVELS] int_level,
   input  logic [1:psi_pkg::NUM_LEVELS] int_mask,
   output logic                         intreq,
   output logic [0:3]                   ic
);
   import psi_pkg::*;

   logic [1:NUM_LEVELS] level_latch;
   logic [1:NUM_LEVELS] active;
   logic [0:3]          lowest;

   always_ff @(posedge clk) begin
      level_latch <= int_level;
   end

   assign active = int_mask & ~level_latch; // inputs are active low.

   // scanning down leaves the lowest active level in place.
   always_comb begin
      lowest = NO_INT_CODE;
      for (int l = NUM_LEVELS; l >= 1; l--) begin
         if (active[l]) begin
            lowest = 4'(l);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         intreq <= 1'b0;
         ic <= 4'b0000;
      end else begin
         intreq <= |active;
         ic <= lowest;
      end
   end

   // level 15 shares its code with the idle value.
   intreq_has_code: assert property (
      @(posedge clk) disable iff (reset)
      intreq |-> (ic != NO_INT_CODE) || $past(active[NUM_LEVELS])
   );

endmodule

//--- rtl/psi_io_core.sv
`timescale 1ns/1ps

module psi_io_core #(
   parameter int PREDIV_BITS = 6
) (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         clk_en,
   input  cru_bus_pkg::cru_cycle_t      cycle,
   input  logic [1:psi_pkg::NUM_INT_IN] int_in,
   input  logic [0:15]                  p_in,
   input  logic                         intreq,
   output logic                         cruin,
   output logic [0:15]                  p_out,
   output logic [0:15]                  p_dir,
   output logic [1:psi_pkg::NUM_LEVELS] int_mask,
   output logic [1:psi_pkg::NUM_LEVELS] int_level
);
   import psi_pkg::*;

   logic                  control_bit;
   logic                  pin_sel;
   logic [3:0]            idx;
   logic [4:0]            alias_pin;
   logic [0:15]           p_pin;
   logic [1:NUM_LEVELS]   raw_level;
   timer_write_t          twrite;
   logic                  hold;
   logic                  clear_int;
   logic [TIMER_BITS:1]   read_reg;
   logic                  timer_run;
   logic                  timer_int;

   assign pin_sel = cycle.s[0];
   assign idx = cycle.s[1:4];
   assign alias_pin = 5'(PIN_ALIAS_BASE) - {1'b0, idx};
   assign p_pin = (p_out & p_dir) | (p_in & ~p_dir); // outputs read back their own value.

   // ************************************************************
   // CRU writes
   // ************************************************************

   always_ff @(posedge clk) begin
      if (reset) begin
         p_out <= '0;
         p_dir <= '0;
         int_mask <= '0;
         control_bit <= 1'b0;
      end else if (cycle.cruclk) begin
         if (pin_sel) begin
            p_out[idx] <= cycle.cruout;
            p_dir[idx] <= 1'b1;
         end else if (idx == CTRL_BIT_ADDR) begin
            control_bit <= cycle.cruout;
         end else if (control_bit) begin
            if (idx == TOP_ADDR && cycle.cruout) begin
               p_out <= '0;
               p_dir <= '0;
               int_mask <= '0;
            end
         end else begin
            int_mask[idx] <= cycle.cruout;
         end
      end
   end

   // clock register bits only exist in clock mode below the top address.
   always_comb begin
      twrite.wr = cycle.cruclk && !pin_sel && control_bit
                  && (idx != CTRL_BIT_ADDR) && (idx != TOP_ADDR);
      twrite.index = idx;
      twrite.value = cycle.cruout;
   end

   assign clear_int = cycle.cruclk && !pin_sel && !control_bit && (idx == 4'(TIMER_LEVEL));
   assign hold = control_bit && !pin_sel;

   psi_timer #(
      .PREDIV_BITS(PREDIV_BITS)
   ) psi_timer_inst (
      .clk(clk),
      .reset(reset),
      .clk_en(clk_en),
      .twrite(twrite),
      .hold(hold),
      .clear_int(clear_int),
      .read_reg(read_reg),
      .timer_run(timer_run),
      .timer_int(timer_int)
   );

   // ************************************************************
   // read multiplexer
   // ************************************************************

   always_comb begin
      if (pin_sel) begin
         cruin = p_pin[idx];
      end else if (idx == CTRL_BIT_ADDR) begin
         cruin = control_bit;
      end else if (control_bit) begin
         cruin = (idx == TOP_ADDR) ? intreq : read_reg[idx];
      end else if (idx <= 4'(NUM_INT_IN)) begin
         cruin = int_in[idx];
      end else begin
         cruin = p_pin[alias_pin[3:0]]; // shared levels count down the pins.
      end
   end

   // ************************************************************
   // interrupt levels
   // ************************************************************

   for (genvar l = 1; l <= NUM_LEVELS; l++) begin : g_level
      if (l <= NUM_INT_IN) begin : g_int
         assign raw_level[l] = int_in[l];
      end else begin : g_pin
         assign raw_level[l] = p_pin[PIN_ALIAS_BASE - l];
      end
   end

   always_comb begin
      int_level = raw_level;
      if (timer_run) begin
         int_level[TIMER_LEVEL] = ~timer_int; // the timer drives level 3 low.
      end
   end

endmodule

//--- rtl/psi_timer.sv
`timescale 1ns/1ps

module psi_timer #(
   parameter int PREDIV_BITS = 6
) (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         clk_en,
   input  psi_pkg::timer_write_t        twrite,
   input  logic                         hold,
   input  logic                         clear_int,
   output logic [psi_pkg::TIMER_BITS:1] read_reg,
   output logic                         timer_run,
   output logic                         timer_int
);
   import psi_pkg::*;

   logic [PREDIV_BITS-1:0] prediv;
   logic [TIMER_BITS:1]    clock_reg;
   logic [TIMER_BITS:1]    clock_next;
   logic [TIMER_BITS:1]    decrementer;
   logic [TIMER_BITS:1]    dec_next;
   logic                   step;
   logic                   terminal;

   // ************************************************************
   // next state
   // ************************************************************

   always_comb begin
      clock_next = clock_reg;
      if (twrite.wr) begin
         clock_next[twrite.index] = twrite.value;
      end
   end

   assign step = clk_en && (prediv == '0) && timer_run;
   // a clock register write restarts the count and wins over terminal count.
   assign terminal = step && (decrementer == '0) && !twrite.wr;

   always_comb begin
      if (twrite.wr) begin
         dec_next = clock_next;
      end else if (terminal) begin
         dec_next = clock_reg;
      end else if (step) begin
         dec_next = decrementer - 1'b1;
      end else begin
         dec_next = decrementer;
      end
   end

   // ************************************************************
   // registers
   // ************************************************************

   always_ff @(posedge clk) begin
      if (reset) begin
         prediv <= '1;
         clock_reg <= '0;
         decrementer <= '0;
         read_reg <= '0;
         timer_run <= 1'b0;
         timer_int <= 1'b0;
      end else begin
         if (clk_en) begin
            prediv <= prediv - 1'b1; // free running.
         end
         clock_reg <= clock_next;
         decrementer <= dec_next;
         if (!hold) begin
            read_reg <= dec_next; // frozen while the CPU reads it.
         end
         if (twrite.wr) begin
            timer_run <= |clock_next;
         end
         if (terminal) begin
            timer_int <= 1'b1;
         end
         if (clear_int) begin
            timer_int <= 1'b0;
         end
      end
   end

   int_only_when_running: assert property (
      @(posedge clk) disable iff (reset)
      $rose(timer_int) |-> timer_run
   );

endmodule

//--- rtl/cru_host_port.sv
`timescale 1ns/1ps

module cru_host_port (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      req,
   input  cru_bus_pkg::cru_request_t request,
   input  logic                      cruin,
   output logic                      ack,
   output logic                      rd_data,
   output cru_bus_pkg::cru_cycle_t   cycle
);
   import cru_bus_pkg::*;
   import psi_pkg::*;

   port_state_t  state;
   logic         req_seen;
   cru_request_t held;

   // ************************************************************
   // handshake sequencing
   // ************************************************************

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= PORT_IDLE;
         req_seen <= 1'b0;
         rd_data <= 1'b0;
         held <= '0;
      end else begin
         req_seen <= req;
         case (state)
            PORT_IDLE: begin
               if (req_seen) begin
                  held <= request; // host keeps request stable until ack.
                  state <= PORT_CYCLE;
               end
            end
            PORT_CYCLE: begin
               rd_data <= (held.op == CRU_READ) ? cruin : 1'b0;
               state <= PORT_ACK;
            end
            PORT_ACK: begin
               if (!req_seen) begin
                  state <= PORT_RELEASE;
               end
            end
            PORT_RELEASE: begin
               state <= PORT_IDLE;
            end
            default: begin
               state <= PORT_IDLE;
            end
         endcase
      end
   end

   assign ack = (state == PORT_ACK);

   // ************************************************************
   // bus cycle drive
   // ************************************************************

   always_comb begin
      cycle.cruclk = (state == PORT_CYCLE) && (held.op == CRU_WRITE);
      cycle.cruout = held.wdata;
      cycle.s = held.addr; // address stays put between transactions.
   end

   // the host must still be asking when the acknowledge comes up.
   ack_needs_req: assert property (
      @(posedge clk) disable iff (reset)
      $rose(ack) |-> $past(req)
   );

   cruclk_single: assert property (
      @(posedge clk) disable iff (reset)
      cycle.cruclk |=> !cycle.cruclk
   );

endmodule

//--- rtl/psi_pkg.sv
package psi_pkg;

   // ************************************************************
   // register map
   // ************************************************************

   localparam int TIMER_BITS = 14;
   localparam int NUM_LEVELS = 15;
   localparam int TIMER_LEVEL = 3;
   localparam int NUM_INT_IN = 6; // levels 1 to 6 have their own inputs.
   localparam int PIN_ALIAS_BASE = 22; // level n shares pin 22 - n.

   localparam logic [0:3] NO_INT_CODE = 4'b1111;
   localparam logic [3:0] CTRL_BIT_ADDR = 4'd0;
   localparam logic [3:0] TOP_ADDR = 4'd15; // soft reset or intreq in clock mode.

   // ************************************************************
   // core to timer
   // ************************************************************

   typedef struct packed {
      logic       wr;
      logic [3:0] index; // clock register bit, 1 to 14.
      logic       value;
   } timer_write_t;

   // ************************************************************
   // host port sequencing
   // ************************************************************

   typedef enum logic [1:0] {
      PORT_IDLE    = 2'd0,
      PORT_CYCLE   = 2'd1,
      PORT_ACK     = 2'd2,
      PORT_RELEASE = 2'd3
   } port_state_t;

endpackage

//--- rtl/cru_bus_pkg.sv
package cru_bus_pkg;

   // ************************************************************
   // host side transaction
   // ************************************************************

   typedef enum logic {
      CRU_READ  = 1'b0,
      CRU_WRITE = 1'b1
   } cru_op_t;

   // one bit per transaction, addr[0] selects the pin space.
   typedef struct packed {
      cru_op_t    op;
      logic [0:4] addr;
      logic       wdata;
   } cru_request_t;

   // ************************************************************
   // CRU bus cycle as seen by the interface core
   // ************************************************************

   typedef struct packed {
      logic       cruclk; // one clock write strobe.
      logic       cruout;
      logic [0:4] s;
   } cru_cycle_t;

endpackage
